// ==== emsys_config.svh ====
/*
  embedded system bus fabric configuration
  widths, address map and reset values shared by all blocks
*/
`ifndef EMSYS_CONFIG_SVH
`define EMSYS_CONFIG_SVH

// --------------------------------------------------
// bus widths
// --------------------------------------------------
`define EMSYS_DATA_W 32
`define EMSYS_ADDR_W 32
`define EMSYS_STRB_W 4

// memory word index, 256 words
`define EMSYS_MEM_AW 8

// --------------------------------------------------
// address map
// --------------------------------------------------
// bit 29 picks the split branch, bit 28 the target within it
`define EMSYS_SEL_HI 29
`define EMSYS_SEL_LO 28

// read data returned with an error response
`define EMSYS_BAD_DATA 32'hdead_dead

// --------------------------------------------------
// control registers
// --------------------------------------------------
// bit 0 of reg 0 set means core running
`define EMSYS_CREG0_RESET 32'h0000_0001
`define EMSYS_NUM_CREGS 2

`endif

// ==== emsys_pkg.sv ====
/*
  embedded system package
  internal bus command, response and host port state types
*/
package emsys_pkg;

  // --------------------------------------------------
  // internal bus
  // --------------------------------------------------

  // command codes, OCP style encoding
  typedef enum logic [1:0] {
    CMD_IDLE = 2'b00,
    CMD_WR   = 2'b01,
    CMD_RD   = 2'b10
  } bus_cmd_e;

  // response codes
  // null means nothing this cycle
  typedef enum logic [1:0] {
    RESP_NULL = 2'b00,
    RESP_DVA  = 2'b01,
    RESP_ERR  = 2'b11
  } bus_resp_e;

  // --------------------------------------------------
  // host port FSM
  // --------------------------------------------------

  // idle until an APB access phase, one cycle of command,
  // then wait for the target response
  typedef enum logic [1:0] {
    ST_IDLE = 2'b00,
    ST_CMD  = 2'b01,
    ST_WAIT = 2'b10
  } host_state_e;

endpackage

// ==== host_port.sv ====
/*
  host port, APB slave front end
  turns each APB transfer into one internal bus command and
  hands the target response back on prdata, pready and pslverr
*/
`include "emsys_config.svh"

module host_port (
  input  logic                        bus,
  input  logic                        reset,
  // APB side
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  logic [`EMSYS_ADDR_W-1:0]    paddr,
  input  logic [`EMSYS_DATA_W-1:0]    pwdata,
  input  logic [`EMSYS_STRB_W-1:0]    pstrb,
  output logic [`EMSYS_DATA_W-1:0]    prdata,
  output logic                        pready,
  output logic                        pslverr,
  // internal bus side
  output emsys_pkg::bus_cmd_e         cmd,
  output logic [`EMSYS_ADDR_W-1:0]    addr,
  output logic [`EMSYS_DATA_W-1:0]    wdata,
  output logic [`EMSYS_STRB_W-1:0]    strb,
  input  emsys_pkg::bus_resp_e        resp,
  input  logic [`EMSYS_DATA_W-1:0]    rdata
);
  import emsys_pkg::*;

  host_state_e              state;
  logic                     access;
  logic                     resp_valid;
  logic [`EMSYS_DATA_W-1:0] readback;

  // APB access phase seen while free
  assign access     = (state == ST_IDLE) && psel && penable;
  assign resp_valid = (state == ST_WAIT) && (resp != RESP_NULL);

  // --------------------------------------------------
  // FSM and command issue
  // --------------------------------------------------
  always_ff @(posedge bus) begin
    if (reset) begin
      state <= ST_IDLE;
      cmd   <= CMD_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (access) begin
            cmd   <= pwrite ? CMD_WR : CMD_RD;
            state <= ST_CMD;
          end
        end
        // command lives for exactly one cycle
        ST_CMD: begin
          cmd   <= CMD_IDLE;
          state <= ST_WAIT;
        end
        ST_WAIT: begin
          if (resp_valid) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          cmd   <= CMD_IDLE;
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // address and data captured with the access phase
  // reads enable all bytes
  always_ff @(posedge bus) begin
    if (access) begin
      addr  <= paddr;
      wdata <= pwdata;
      strb  <= pwrite ? pstrb : '1;
    end
  end

  // --------------------------------------------------
  // readback
  // --------------------------------------------------
  // cleared while a command is out, loaded with the response
  always_ff @(posedge bus) begin
    if (state == ST_CMD) begin
      readback <= `EMSYS_BAD_DATA;
    end else if (resp_valid) begin
      readback <= rdata;
    end
  end

  // response cycle passes rdata straight through
  assign prdata  = resp_valid ? rdata : readback;
  assign pready  = resp_valid;
  assign pslverr = resp_valid && (resp == RESP_ERR);

  // responses only while a command is outstanding
  a_resp_in_wait : assert property (
    @(posedge bus) disable iff (reset)
    (resp != RESP_NULL) |-> (state == ST_WAIT)
  ) else $error("host_port: response outside ST_WAIT");

endmodule

// ==== addr_split.sv ====
/*
  address split
  decodes select bits 29:28 and the word index range, routes each
  command to the memory, the control registers or an error responder
*/
`include "emsys_config.svh"

module addr_split (
  input  logic                        bus,
  input  logic                        reset,
  // host side
  input  emsys_pkg::bus_cmd_e         cmd,
  input  logic [`EMSYS_ADDR_W-1:0]    addr,
  input  logic [`EMSYS_DATA_W-1:0]    wdata,
  input  logic [`EMSYS_STRB_W-1:0]    strb,
  output emsys_pkg::bus_resp_e        resp,
  output logic [`EMSYS_DATA_W-1:0]    rdata,
  // processor memory
  output emsys_pkg::bus_cmd_e         mem_cmd,
  output logic [`EMSYS_MEM_AW-1:0]    mem_addr,
  output logic [`EMSYS_DATA_W-1:0]    mem_wdata,
  output logic [`EMSYS_STRB_W-1:0]    mem_strb,
  input  emsys_pkg::bus_resp_e        mem_resp,
  input  logic [`EMSYS_DATA_W-1:0]    mem_rdata,
  // control registers
  output emsys_pkg::bus_cmd_e         creg_cmd,
  output logic [`EMSYS_MEM_AW-1:0]    creg_addr,
  output logic [`EMSYS_DATA_W-1:0]    creg_wdata,
  output logic [`EMSYS_STRB_W-1:0]    creg_strb,
  input  emsys_pkg::bus_resp_e        creg_resp,
  input  logic [`EMSYS_DATA_W-1:0]    creg_rdata
);
  import emsys_pkg::*;

  // byte address to word index
  localparam int IDX_LO = 2;
  localparam int IDX_HI = IDX_LO + `EMSYS_MEM_AW - 1;

  localparam logic [1:0] REGION_MEM  = 2'd0;
  localparam logic [1:0] REGION_CREG = 2'd1;

  logic [1:0] region;
  logic       cmd_active;
  logic       idx_in_range;
  logic       mem_hit;
  logic       creg_hit;
  logic       err_hit;
  logic       mem_q;
  logic       creg_q;
  logic       err_q;

  // --------------------------------------------------
  // decode
  // --------------------------------------------------
  assign region     = addr[`EMSYS_SEL_HI:`EMSYS_SEL_LO];
  assign cmd_active = (cmd != CMD_IDLE);

  // index bits above the memory depth must be clear
  assign idx_in_range = (addr[`EMSYS_SEL_LO-1:IDX_HI+1] == '0);

  assign mem_hit  = cmd_active && (region == REGION_MEM) && idx_in_range;
  assign creg_hit = cmd_active && (region == REGION_CREG);
  // jtag and freq synth regions, plus out of range memory
  assign err_hit  = cmd_active && !mem_hit && !creg_hit;

  assign mem_cmd    = mem_hit ? cmd : CMD_IDLE;
  assign mem_addr   = addr[IDX_HI:IDX_LO];
  assign mem_wdata  = wdata;
  assign mem_strb   = strb;

  assign creg_cmd   = creg_hit ? cmd : CMD_IDLE;
  assign creg_addr  = addr[IDX_HI:IDX_LO];
  assign creg_wdata = wdata;
  assign creg_strb  = strb;

  // --------------------------------------------------
  // destination, one cycle
  // --------------------------------------------------
  always_ff @(posedge bus) begin
    if (reset) begin
      mem_q  <= 1'b0;
      creg_q <= 1'b0;
      err_q  <= 1'b0;
    end else begin
      mem_q  <= mem_hit;
      creg_q <= creg_hit;
      err_q  <= err_hit;
    end
  end

  // response merge
  always_comb begin
    resp  = RESP_NULL;
    rdata = '0;
    if (err_q) begin
      resp  = RESP_ERR;
      rdata = `EMSYS_BAD_DATA;
    end else if (mem_q) begin
      resp  = mem_resp;
      rdata = mem_rdata;
    end else if (creg_q) begin
      resp  = creg_resp;
      rdata = creg_rdata;
    end
  end

  // at most one target answers in any cycle
  a_one_target : assert property (
    @(posedge bus) disable iff (reset)
    $onehot0({mem_resp != RESP_NULL, creg_resp != RESP_NULL, err_q})
  ) else $error("addr_split: more than one target answering");

endmodule

// ==== proc_mem.sv ====
/*
  processor memory block
  256 word array with byte enabled writes, responds one cycle later
*/
`include "emsys_config.svh"

module proc_mem (
  input  logic                        bus,
  input  logic                        reset,
  input  emsys_pkg::bus_cmd_e         cmd,
  input  logic [`EMSYS_MEM_AW-1:0]    addr,
  input  logic [`EMSYS_DATA_W-1:0]    wdata,
  input  logic [`EMSYS_STRB_W-1:0]    strb,
  output emsys_pkg::bus_resp_e        resp,
  output logic [`EMSYS_DATA_W-1:0]    rdata
);
  import emsys_pkg::*;

  localparam int DEPTH = 1 << `EMSYS_MEM_AW;

  logic [`EMSYS_DATA_W-1:0] mem [DEPTH];

  // --------------------------------------------------
  // storage
  // --------------------------------------------------
  always_ff @(posedge bus) begin
    if (cmd == CMD_WR) begin
      for (int b = 0; b < `EMSYS_STRB_W; b++) begin
        if (strb[b]) begin
          mem[addr][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  // read data, zero for writes
  always_ff @(posedge bus) begin
    rdata <= (cmd == CMD_RD) ? mem[addr] : '0;
  end

  // every command answered next cycle
  always_ff @(posedge bus) begin
    if (reset) begin
      resp <= RESP_NULL;
    end else begin
      resp <= (cmd != CMD_IDLE) ? RESP_DVA : RESP_NULL;
    end
  end

  // split must filter indices beyond the array
  a_addr_range : assert property (
    @(posedge bus) disable iff (reset)
    (cmd != CMD_IDLE) |-> (!$isunknown(addr) && (int'(addr) < DEPTH))
  ) else $error("proc_mem: access to index %0d out of range", addr);

endmodule

// ==== ctrl_regs.sv ====
/*
  global control registers
  reg 0 bit 0 keeps the core out of reset, reg 1 drives the LEDs
*/
`include "emsys_config.svh"

module ctrl_regs (
  input  logic                        bus,
  input  logic                        reset,
  input  emsys_pkg::bus_cmd_e         cmd,
  input  logic [`EMSYS_MEM_AW-1:0]    addr,
  input  logic [`EMSYS_DATA_W-1:0]    wdata,
  input  logic [`EMSYS_STRB_W-1:0]    strb,
  output emsys_pkg::bus_resp_e        resp,
  output logic [`EMSYS_DATA_W-1:0]    rdata,
  output logic                        core_reset,
  output logic                        status_led,
  output logic [3:0]                  gpled
);
  import emsys_pkg::*;

  localparam int IDX_W = (`EMSYS_NUM_CREGS > 1) ? $clog2(`EMSYS_NUM_CREGS) : 1;

  logic [`EMSYS_DATA_W-1:0] creg [`EMSYS_NUM_CREGS];
  logic                     idx_valid;
  logic [IDX_W-1:0]         widx;

  // unused indices read zero
  assign idx_valid = (int'(addr) < `EMSYS_NUM_CREGS);
  assign widx      = addr[IDX_W-1:0];

  // --------------------------------------------------
  // registers
  // --------------------------------------------------
  always_ff @(posedge bus) begin
    if (reset) begin
      for (int i = 0; i < `EMSYS_NUM_CREGS; i++) begin
        creg[i] <= (i == 0) ? `EMSYS_CREG0_RESET : '0;
      end
    end else if ((cmd == CMD_WR) && idx_valid) begin
      for (int b = 0; b < `EMSYS_STRB_W; b++) begin
        if (strb[b]) begin
          creg[widx][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  // response path
  always_ff @(posedge bus) begin
    if (reset) begin
      resp <= RESP_NULL;
    end else begin
      resp <= (cmd != CMD_IDLE) ? RESP_DVA : RESP_NULL;
    end
  end

  always_ff @(posedge bus) begin
    rdata <= ((cmd == CMD_RD) && idx_valid) ? creg[widx] : '0;
  end

  // --------------------------------------------------
  // outputs
  // --------------------------------------------------
  // core held in reset while bit 0 is clear
  assign core_reset = ~creg[0][0];
  assign status_led = ~reset & ~core_reset;
  assign gpled      = creg[1][3:0];

endmodule

// ==== emsys_top.sv ====
/*
  embedded system bus fabric top level
  APB host port, address split, processor memory, control registers
*/
`include "emsys_config.svh"

module emsys_top (
  input  logic                        bus,
  input  logic                        reset,
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  logic [`EMSYS_ADDR_W-1:0]    paddr,
  input  logic [`EMSYS_DATA_W-1:0]    pwdata,
  input  logic [`EMSYS_STRB_W-1:0]    pstrb,
  output logic [`EMSYS_DATA_W-1:0]    prdata,
  output logic                        pready,
  output logic                        pslverr,
  output logic                        core_reset,
  output logic                        status_led,
  output logic [3:0]                  gpled
);
  import emsys_pkg::*;

  // --------------------------------------------------
  // host to split
  // --------------------------------------------------
  bus_cmd_e                 host_cmd;
  logic [`EMSYS_ADDR_W-1:0] host_addr;
  logic [`EMSYS_DATA_W-1:0] host_wdata;
  logic [`EMSYS_STRB_W-1:0] host_strb;
  bus_resp_e                host_resp;
  logic [`EMSYS_DATA_W-1:0] host_rdata;

  // split to memory
  bus_cmd_e                 mem_cmd;
  logic [`EMSYS_MEM_AW-1:0] mem_addr;
  logic [`EMSYS_DATA_W-1:0] mem_wdata;
  logic [`EMSYS_STRB_W-1:0] mem_strb;
  bus_resp_e                mem_resp;
  logic [`EMSYS_DATA_W-1:0] mem_rdata;

  // split to control registers
  bus_cmd_e                 creg_cmd;
  logic [`EMSYS_MEM_AW-1:0] creg_addr;
  logic [`EMSYS_DATA_W-1:0] creg_wdata;
  logic [`EMSYS_STRB_W-1:0] creg_strb;
  bus_resp_e                creg_resp;
  logic [`EMSYS_DATA_W-1:0] creg_rdata;

  host_port i_host_port (
    .bus(bus), .reset(reset),
    .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .pstrb(pstrb),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .cmd(host_cmd), .addr(host_addr), .wdata(host_wdata), .strb(host_strb),
    .resp(host_resp), .rdata(host_rdata)
  );

  addr_split i_addr_split (
    .bus(bus), .reset(reset),
    .cmd(host_cmd), .addr(host_addr), .wdata(host_wdata), .strb(host_strb),
    .resp(host_resp), .rdata(host_rdata),
    .mem_cmd(mem_cmd), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_strb(mem_strb), .mem_resp(mem_resp), .mem_rdata(mem_rdata),
    .creg_cmd(creg_cmd), .creg_addr(creg_addr), .creg_wdata(creg_wdata),
    .creg_strb(creg_strb), .creg_resp(creg_resp), .creg_rdata(creg_rdata)
  );

  // --------------------------------------------------
  // targets
  // --------------------------------------------------
  proc_mem i_proc_mem (
    .bus(bus), .reset(reset),
    .cmd(mem_cmd), .addr(mem_addr), .wdata(mem_wdata), .strb(mem_strb),
    .resp(mem_resp), .rdata(mem_rdata)
  );

  ctrl_regs i_ctrl_regs (
    .bus(bus), .reset(reset),
    .cmd(creg_cmd), .addr(creg_addr), .wdata(creg_wdata), .strb(creg_strb),
    .resp(creg_resp), .rdata(creg_rdata),
    .core_reset(core_reset), .status_led(status_led), .gpled(gpled)
  );

endmodule

// ==== tb_clock.sv ====
/*
  testbench clock and reset generator
  free running clock, synchronous reset held for a few cycles
*/
module tb_clock #(
  parameter int PERIOD       = 4,
  parameter int RESET_CYCLES = 5
) (
  output logic bus,
  output logic reset
);

  // clock starts low, first rising edge after half a period
  initial begin
    bus = 1'b0;
    forever begin
      #(PERIOD / 2) bus = ~bus;
    end
  end

  // reset released right after a rising edge
  initial begin
    reset <= 1'b1;
    repeat (RESET_CYCLES) @(posedge bus);
    reset <= 1'b0;
  end

endmodule

// ==== tb_emsys.sv ====
/*
  testbench for the embedded system bus fabric
  replays APB transfers from the case file and checks read data,
  pslverr, the LEDs, core reset and the number of wait states
*/
`include "emsys_config.svh"

module tb_emsys;

  // --------------------------------------------------
  // testbench constants
  // --------------------------------------------------
  localparam int          CLK_PERIOD      = 4;
  localparam int          RESET_CYCLES    = 5;
  localparam string       CASE_FILE       = "emsys_cases.txt";
  localparam int          MAX_CASES       = 64;
  localparam int          FIELDS          = 8;
  localparam int          CYCLES_PER_CASE = 20;
  localparam int          CYCLE_SLACK     = 50;
  // response lands in the third access cycle
  localparam int          WAIT_STATES     = 2;
  localparam logic [31:0] OP_READ         = 32'h0000_0000;
  localparam logic [31:0] OP_WRITE        = 32'h0000_0001;
  localparam logic [31:0] OP_END          = 32'h0000_000f;

  logic                     bus;
  logic                     reset;
  logic                     psel;
  logic                     penable;
  logic                     pwrite;
  logic [`EMSYS_ADDR_W-1:0] paddr;
  logic [`EMSYS_DATA_W-1:0] pwdata;
  logic [`EMSYS_STRB_W-1:0] pstrb;
  logic [`EMSYS_DATA_W-1:0] prdata;
  logic                     pready;
  logic                     pslverr;
  logic                     core_reset;
  logic                     status_led;
  logic [3:0]               gpled;

  // flat case table, FIELDS words per case
  logic [`EMSYS_DATA_W-1:0] cases_mem [MAX_CASES*FIELDS];

  int data_errors      = 0;
  int err_errors       = 0;
  int led_errors       = 0;
  int handshake_errors = 0;
  int file_errors      = 0;
  int cycle_count      = 0;
  int cycle_limit      = CYCLE_SLACK;

  tb_clock #(
    .PERIOD(CLK_PERIOD),
    .RESET_CYCLES(RESET_CYCLES)
  ) i_clock (
    .bus(bus),
    .reset(reset)
  );

  emsys_top i_dut (
    .bus(bus), .reset(reset),
    .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .pstrb(pstrb),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .core_reset(core_reset), .status_led(status_led), .gpled(gpled)
  );

  always @(posedge bus) begin
    cycle_count <= cycle_count + 1;
  end

  // --------------------------------------------------
  // compare tasks
  // --------------------------------------------------
  task automatic check_data(input int idx, input logic [`EMSYS_DATA_W-1:0] got,
                            input logic [`EMSYS_DATA_W-1:0] exp);
    if (got !== exp) begin
      data_errors++;
      $display("error at %0t: case %0d prdata %h, expected %h", $time, idx, got, exp);
    end
  endtask

  task automatic check_err(input int idx, input logic got, input logic exp);
    if (got !== exp) begin
      err_errors++;
      $display("error at %0t: case %0d pslverr %b, expected %b", $time, idx, got, exp);
    end
  endtask

  task automatic check_leds(input int idx, input logic [3:0] got_gp,
                            input logic [3:0] exp_gp, input logic got_st,
                            input logic exp_st, input logic got_cr,
                            input logic exp_cr);
    if ((got_gp !== exp_gp) || (got_st !== exp_st) || (got_cr !== exp_cr)) begin
      led_errors++;
      $display("error at %0t: case %0d gpled %h status %b core_reset %b, expected %h %b %b",
               $time, idx, got_gp, got_st, got_cr, exp_gp, exp_st, exp_cr);
    end
  endtask

  task automatic check_waits(input int idx, input int got, input int exp);
    if (got != exp) begin
      handshake_errors++;
      $display("error at %0t: case %0d pready after %0d wait states, expected %0d",
               $time, idx, got, exp);
    end
  endtask

  // one APB transfer, outputs sampled on the falling edge
  task automatic apb_transfer(
    input  logic                     write,
    input  logic [`EMSYS_ADDR_W-1:0] a,
    input  logic [`EMSYS_DATA_W-1:0] wd,
    input  logic [`EMSYS_STRB_W-1:0] s,
    output logic [`EMSYS_DATA_W-1:0] rd,
    output logic                     err,
    output logic [3:0]               gp,
    output logic                     st,
    output logic                     cr,
    output int                       waits
  );
    waits = 0;
    // setup phase
    @(posedge bus);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= a;
    pwdata  <= wd;
    pstrb   <= s;
    // access phase, held until pready
    @(posedge bus);
    penable <= 1'b1;
    @(negedge bus);
    while (!pready) begin
      waits++;
      @(negedge bus);
    end
    rd  = prdata;
    err = pslverr;
    gp  = gpled;
    st  = status_led;
    cr  = core_reset;
    // master sees pready at this edge and ends the transfer
    @(posedge bus);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  function automatic int total_errors();
    return data_errors + err_errors + led_errors + handshake_errors + file_errors;
  endfunction

  task automatic report_counts();
    $display("summary: data %0d, pslverr %0d, leds %0d, handshake %0d, case file %0d",
             data_errors, err_errors, led_errors, handshake_errors, file_errors);
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin : main
    int                       num_cases;
    int                       base;
    logic [31:0]              op;
    logic [`EMSYS_DATA_W-1:0] rd;
    logic                     err;
    logic [3:0]               gp;
    logic                     st;
    logic                     cr;
    int                       waits;

    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= '0;
    pwdata  <= '0;
    pstrb   <= '0;

    $readmemh(CASE_FILE, cases_mem);
    // number of cases, up to the end marker
    num_cases = -1;
    for (int k = 0; k < MAX_CASES; k++) begin
      if ((num_cases < 0) && (cases_mem[k*FIELDS] == OP_END)) begin
        num_cases = k;
      end
    end
    if (num_cases <= 0) begin
      file_errors++;
      $display("case file %s is missing, empty or has no end marker", CASE_FILE);
    end else begin
      cycle_limit = CYCLES_PER_CASE * num_cases + CYCLE_SLACK;
    end

    @(posedge bus);
    while (reset) begin
      @(posedge bus);
    end

    for (int k = 0; k < num_cases; k++) begin
      base = k * FIELDS;
      op   = cases_mem[base];
      if ((op != OP_READ) && (op != OP_WRITE)) begin
        file_errors++;
        $display("case %0d has an unknown operation code %h", k, op);
      end else begin
        apb_transfer(op == OP_WRITE, cases_mem[base+1], cases_mem[base+2],
                     cases_mem[base+3][`EMSYS_STRB_W-1:0], rd, err, gp, st, cr, waits);
        check_data(k, rd, cases_mem[base+4]);
        check_err(k, err, cases_mem[base+5][0]);
        // out of reset the status led is lit exactly while the core runs
        check_leds(k, gp, cases_mem[base+6][3:0], st, cases_mem[base+7][0],
                   cr, !cases_mem[base+7][0]);
        check_waits(k, waits, WAIT_STATES);
      end
    end

    report_counts();
    if (total_errors() == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // stops a hung transfer
  initial begin : watchdog
    wait (cycle_count >= cycle_limit);
    $display("timeout: the cases did not finish within %0d cycles", cycle_limit);
    report_counts();
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== emsys_cases.txt ====
// op addr wdata strb exp_rdata exp_pslverr exp_gpled exp_status_led
// op 0 read, 1 write, f end of cases
// reset state of register 0
0 10000000 00000000 0 00000001 0 0 1
// memory write then read back
1 00000010 11223344 f 00000000 0 0 1
0 00000010 00000000 0 11223344 0 0 1
1 00000000 01020304 f 00000000 0 0 1
0 00000000 00000000 0 01020304 0 0 1
// partial strobe, bytes 0 and 2
1 00000010 aabbccdd 5 00000000 0 0 1
0 00000010 00000000 0 11bb33dd 0 0 1
// last word, bytes 1 and 3
1 000003fc 0badf00d f 00000000 0 0 1
0 000003fc 00000000 0 0badf00d 0 0 1
1 000003fc ffffffff a 00000000 0 0 1
0 000003fc 00000000 0 ffadff0d 0 0 1
// core reset bit and status led
1 10000000 00000000 f 00000000 0 0 0
0 10000000 00000000 0 00000000 0 0 0
1 10000000 00000001 1 00000000 0 0 1
0 10000000 00000000 0 00000001 0 0 1
// general purpose leds
1 10000004 000000a5 f 00000000 0 5 1
0 10000004 00000000 0 000000a5 0 5 1
1 10000004 00000c0c 2 00000000 0 5 1
0 10000004 00000000 0 00000ca5 0 5 1
// jtag and frequency synthesis regions
1 20000010 12345678 f deaddead 1 5 1
0 20000000 00000000 0 deaddead 1 5 1
1 30000010 87654321 f deaddead 1 5 1
0 30000004 00000000 0 deaddead 1 5 1
0 00000010 00000000 0 11bb33dd 0 5 1
// memory word index past the end
0 00000400 00000000 0 deaddead 1 5 1
1 00000400 cafef00d f deaddead 1 5 1
0 0ffffffc 00000000 0 deaddead 1 5 1
0 00000000 00000000 0 01020304 0 5 1
// unused register index
1 10000008 ffffffff f 00000000 0 5 1
0 10000008 00000000 0 00000000 0 5 1
0 10000004 00000000 0 00000ca5 0 5 1
// end marker
f 0 0 0 0 0 0 0

// ==== tb.f ====
+incdir+.
emsys_pkg.sv
host_port.sv
addr_split.sv
proc_mem.sv
ctrl_regs.sv
emsys_top.sv
tb_clock.sv
tb_emsys.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the emsys testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --assert --top-module tb_emsys -f tb.f -o Vtb_emsys; then
  echo "build failed"
  exit 1
fi

if ! ./obj_dir/Vtb_emsys > "$LOG" 2>&1; then
  cat "$LOG"
  echo "simulation exited with an error"
  exit 1
fi

cat "$LOG"

if grep -q "ERRORS FOUND" "$LOG"; then
  echo "test failed"
  exit 1
fi

echo "test passed"
exit 0
